// ==== src/soc_defines.svh ====
/* region nibble is address bits 31:28, so each region spans 256 MB
   register offsets decode address bits 7:0 only and alias above that */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_SEL_W       4

// ------------------------------------------------------------
// address map
// ------------------------------------------------------------
`define SOC_REGION_MSB  31
`define SOC_REGION_LSB  28
`define SOC_REGION_ROM  4'h0
`define SOC_REGION_GPIO 4'h1
`define SOC_REGION_SYS  4'h2

`define SOC_ROM_WORDS   16

`define SOC_GPIO_OUT    8'h00
`define SOC_GPIO_OE     8'h04
`define SOC_GPIO_IN     8'h08

`define SOC_SYS_STRAP   8'h00
`define SOC_SYS_REMAP   8'h04

`endif

// ==== src/soc_pkg.sv ====
/* bus types and the fixed boot image, shared by RTL and testbench */
`default_nettype none
`include "soc_defines.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;
  typedef logic [`SOC_DATA_W-1:0] bus_data_t;
  typedef logic [`SOC_SEL_W-1:0]  bus_sel_t;
  typedef logic [`SOC_REGION_MSB-`SOC_REGION_LSB:0] region_t;
  typedef logic [1:0] boot_remap_t;  // 0 = no remap
  typedef logic [3:0] boot_strap_t;

  typedef enum logic [1:0] {
    SLV_ROM,
    SLV_GPIO,
    SLV_SYS,
    SLV_NONE
  } slave_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_INSN,
    ARB_DATA
  } arb_state_e;

  // boot image, one word per entry
  localparam bus_data_t BOOT_ROM_IMAGE [`SOC_ROM_WORDS] = '{
    32'h1800_0000, 32'hA840_0000, 32'h1860_2000, 32'hA863_0004,
    32'h8483_0000, 32'hE4A4_0000, 32'h1000_0003, 32'h1500_0000,
    32'h1880_1000, 32'hD404_1800, 32'h4400_2000, 32'h1500_0000,
    32'h0000_0000, 32'h1500_0000, 32'hDEAD_BEEF, 32'hC0DE_F00D
  };

endpackage

`default_nettype wire

// ==== src/soc_bus_if.sv ====
/* single-beat strobe/ack bus, no retry and no bursts */
`default_nettype none

interface soc_bus_if import soc_pkg::*; ();

  logic      cyc;
  logic      stb;
  logic      we;
  bus_sel_t  sel;
  bus_addr_t adr;
  bus_data_t dat_w;
  bus_data_t dat_r;
  logic      ack;

  // arbiter side
  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack
  );

  // slave side
  modport target (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// ==== src/soc_remap_decode.sv ====
/* purely combinational, one instance per master
   remap only applies to region 0 */
`default_nettype none
`include "soc_defines.svh"

module soc_remap_decode import soc_pkg::*; (
  input  bus_addr_t   adr_i,
  input  boot_remap_t boot_remap_i,
  output bus_addr_t   adr_o,
  output slave_e      slave_o
);

  region_t region_in;
  region_t region_out;

  assign region_in = adr_i[`SOC_REGION_MSB:`SOC_REGION_LSB];

  // boot region follows the remap register
  assign region_out = (boot_remap_i != '0 && region_in == `SOC_REGION_ROM) ?
                      region_t'(boot_remap_i) : region_in;

  assign adr_o = {region_out, adr_i[`SOC_REGION_LSB-1:0]};

  always_comb begin
    case (region_out)
      `SOC_REGION_ROM:  slave_o = SLV_ROM;
      `SOC_REGION_GPIO: slave_o = SLV_GPIO;
      `SOC_REGION_SYS:  slave_o = SLV_SYS;
      default:          slave_o = SLV_NONE;  // unmapped, arbiter errors it
    endcase
  end

endmodule

`default_nettype wire

// ==== src/soc_bus_arbiter.sv ====
/* data master has fixed priority, grant is held for the whole cyc
   unmapped accesses get err one cycle after stb and are never forwarded */
`default_nettype none
`include "soc_defines.svh"

module soc_bus_arbiter import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // instruction master
  input  logic       i_cyc_i,
  input  logic       i_stb_i,
  input  logic       i_we_i,
  input  bus_sel_t   i_sel_i,
  input  bus_addr_t  i_adr_i,
  input  bus_data_t  i_dat_i,
  input  slave_e     i_slave_i,
  output bus_data_t  i_dat_o,
  output logic       i_ack_o,
  output logic       i_err_o,
  // data master
  input  logic       d_cyc_i,
  input  logic       d_stb_i,
  input  logic       d_we_i,
  input  bus_sel_t   d_sel_i,
  input  bus_addr_t  d_adr_i,
  input  bus_data_t  d_dat_i,
  input  slave_e     d_slave_i,
  output bus_data_t  d_dat_o,
  output logic       d_ack_o,
  output logic       d_err_o,
  // slave buses
  soc_bus_if.master  rom_bus,
  soc_bus_if.master  gpio_bus,
  soc_bus_if.master  sys_bus
);

  arb_state_e state_q, state_d;
  logic       grant_i, grant_d;
  logic       g_cyc, g_stb, g_we;
  bus_sel_t   g_sel;
  bus_addr_t  g_adr;
  bus_data_t  g_dat;
  slave_e     g_slave;
  bus_data_t  r_dat;
  logic       r_ack;
  logic       err_q;

  // ------------------------------------------------------------
  // grant FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (d_cyc_i) state_d = ARB_DATA;  // data wins a tie
        else if (i_cyc_i) state_d = ARB_INSN;
      end
      ARB_INSN: if (!i_cyc_i) state_d = ARB_IDLE;
      ARB_DATA: if (!d_cyc_i) state_d = ARB_IDLE;
      default:  state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= ARB_IDLE;
    else state_q <= state_d;
  end

  assign grant_i = (state_q == ARB_INSN);
  assign grant_d = (state_q == ARB_DATA);

  // granted master onto one shared request
  assign g_cyc   = (grant_i & i_cyc_i) | (grant_d & d_cyc_i);
  assign g_stb   = (grant_i & i_stb_i) | (grant_d & d_stb_i);
  assign g_we    = grant_d ? d_we_i : i_we_i;
  assign g_sel   = grant_d ? d_sel_i : i_sel_i;
  assign g_adr   = grant_d ? d_adr_i : i_adr_i;
  assign g_dat   = grant_d ? d_dat_i : i_dat_i;
  assign g_slave = grant_d ? d_slave_i : (grant_i ? i_slave_i : SLV_NONE);

  // ------------------------------------------------------------
  // slave buses, only the selected one sees cyc/stb
  // ------------------------------------------------------------
  assign rom_bus.cyc   = g_cyc & (g_slave == SLV_ROM);
  assign rom_bus.stb   = g_stb & (g_slave == SLV_ROM);
  assign rom_bus.we    = g_we;
  assign rom_bus.sel   = g_sel;
  assign rom_bus.adr   = g_adr;
  assign rom_bus.dat_w = g_dat;

  assign gpio_bus.cyc   = g_cyc & (g_slave == SLV_GPIO);
  assign gpio_bus.stb   = g_stb & (g_slave == SLV_GPIO);
  assign gpio_bus.we    = g_we;
  assign gpio_bus.sel   = g_sel;
  assign gpio_bus.adr   = g_adr;
  assign gpio_bus.dat_w = g_dat;

  assign sys_bus.cyc   = g_cyc & (g_slave == SLV_SYS);
  assign sys_bus.stb   = g_stb & (g_slave == SLV_SYS);
  assign sys_bus.we    = g_we;
  assign sys_bus.sel   = g_sel;
  assign sys_bus.adr   = g_adr;
  assign sys_bus.dat_w = g_dat;

  always_comb begin
    case (g_slave)
      SLV_ROM:  begin r_dat = rom_bus.dat_r;  r_ack = rom_bus.ack;  end
      SLV_GPIO: begin r_dat = gpio_bus.dat_r; r_ack = gpio_bus.ack; end
      SLV_SYS:  begin r_dat = sys_bus.dat_r;  r_ack = sys_bus.ack;  end
      default:  begin r_dat = {`SOC_DATA_W{1'b0}}; r_ack = 1'b0; end
    endcase
  end

  // error termination, single pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) err_q <= 1'b0;
    else err_q <= g_stb & (g_slave == SLV_NONE) & ~err_q;
  end

  // response goes back to the granted master only
  assign i_dat_o = grant_i ? r_dat : '0;
  assign i_ack_o = grant_i & r_ack;
  assign i_err_o = grant_i & err_q;
  assign d_dat_o = grant_d ? r_dat : '0;
  assign d_ack_o = grant_d & r_ack;
  assign d_err_o = grant_d & err_q;

endmodule

`default_nettype wire

// ==== src/soc_boot_rom.sv ====
/* writes are acked and dropped, addresses wrap every 16 words */
`default_nettype none
`include "soc_defines.svh"

module soc_boot_rom import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  soc_bus_if.target bus
);

  logic [$clog2(`SOC_ROM_WORDS)-1:0] word_idx;
  logic      access;
  logic      ack_q;
  bus_data_t dat_q;

  assign word_idx = bus.adr[$clog2(`SOC_ROM_WORDS)+1:2];  // word address
  assign access   = bus.cyc & bus.stb;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) ack_q <= 1'b0;
    else ack_q <= access & ~ack_q;  // one pulse per access
  end

  always_ff @(posedge clk_i) begin
    if (access) dat_q <= BOOT_ROM_IMAGE[word_idx];
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

// ==== src/soc_sys_ctrl.sv ====
/* strap is sampled on every clock while rst_n_i is low, so the clock must run in reset
   remap write uses byte lane 0 only */
`default_nettype none
`include "soc_defines.svh"

module soc_sys_ctrl import soc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  boot_strap_t boot_strap_i,
  soc_bus_if.target   bus,
  output boot_remap_t boot_remap_o
);

  logic [7:0]  offset;
  logic        access;
  logic        ack_q;
  bus_data_t   dat_q;
  boot_strap_t strap_q;
  boot_remap_t remap_q;

  assign offset = bus.adr[7:0];
  assign access = bus.cyc & bus.stb;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      strap_q <= boot_strap_i;
      remap_q <= boot_strap_i[1:0];  // boot remap follows the board strap
      ack_q   <= 1'b0;
    end else begin
      ack_q <= access & ~ack_q;
      // new remap is live in the ack cycle
      if (access && !ack_q && bus.we && bus.sel[0] && offset == `SOC_SYS_REMAP)
        remap_q <= bus.dat_w[1:0];
    end
  end

  // read mux
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (offset)
        `SOC_SYS_STRAP: dat_q <= bus_data_t'(strap_q);  // read only
        `SOC_SYS_REMAP: dat_q <= bus_data_t'(remap_q);
        default:        dat_q <= '0;
      endcase
    end
  end

  assign bus.ack      = ack_q;
  assign bus.dat_r    = dat_q;
  assign boot_remap_o = remap_q;

endmodule

`default_nettype wire

// ==== src/soc_gpio.sv ====
/* one 32-bit port, no interrupts
   pad input is seen two clocks late through the synchronizer */
`default_nettype none
`include "soc_defines.svh"

module soc_gpio import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  soc_bus_if.target bus,
  input  bus_data_t gpio_pad_i,
  output bus_data_t gpio_pad_o,
  output bus_data_t gpio_padoe_o
);

  logic [7:0] offset;
  logic       access;
  logic       wr_en;
  logic       ack_q;
  bus_data_t  dat_q;
  bus_data_t  out_q, oe_q;
  bus_data_t  in_meta, in_sync;

  assign offset = bus.adr[7:0];
  assign access = bus.cyc & bus.stb;
  assign wr_en  = access & bus.we & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      out_q <= '0;
      oe_q  <= '0;  // pads start as inputs
    end else begin
      ack_q <= access & ~ack_q;
      for (int b = 0; b < `SOC_SEL_W; b++) begin
        if (wr_en && bus.sel[b] && offset == `SOC_GPIO_OUT) out_q[8*b +: 8] <= bus.dat_w[8*b +: 8];
        if (wr_en && bus.sel[b] && offset == `SOC_GPIO_OE) oe_q[8*b +: 8] <= bus.dat_w[8*b +: 8];
      end
    end
  end

  // 2-flop input sync
  always_ff @(posedge clk_i) begin
    in_meta <= gpio_pad_i;
    in_sync <= in_meta;
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      case (offset)
        `SOC_GPIO_OUT: dat_q <= out_q;
        `SOC_GPIO_OE:  dat_q <= oe_q;
        `SOC_GPIO_IN:  dat_q <= in_sync;
        default:       dat_q <= '0;
      endcase
    end
  end

  assign bus.ack      = ack_q;
  assign bus.dat_r    = dat_q;
  assign gpio_pad_o   = out_q;
  assign gpio_padoe_o = oe_q;

endmodule

`default_nettype wire

// ==== src/soc_top.sv ====
/* two masters (instruction and data) share ROM, GPIO and system control
   one clock domain, synchronous active-low reset */
`default_nettype none
`include "soc_defines.svh"

module soc_top import soc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  boot_strap_t boot_strap_i,
  input  bus_data_t   gpio_pad_i,
  output bus_data_t   gpio_pad_o,
  output bus_data_t   gpio_padoe_o,
  // instruction master
  input  logic        iwb_cyc_i,
  input  logic        iwb_stb_i,
  input  logic        iwb_we_i,
  input  bus_sel_t    iwb_sel_i,
  input  bus_addr_t   iwb_adr_i,
  input  bus_data_t   iwb_dat_i,
  output bus_data_t   iwb_dat_o,
  output logic        iwb_ack_o,
  output logic        iwb_err_o,
  // data master
  input  logic        dwb_cyc_i,
  input  logic        dwb_stb_i,
  input  logic        dwb_we_i,
  input  bus_sel_t    dwb_sel_i,
  input  bus_addr_t   dwb_adr_i,
  input  bus_data_t   dwb_dat_i,
  output bus_data_t   dwb_dat_o,
  output logic        dwb_ack_o,
  output logic        dwb_err_o
);

  boot_remap_t boot_remap;
  bus_addr_t   iwb_adr_remap, dwb_adr_remap;
  slave_e      iwb_slave, dwb_slave;

  soc_bus_if rom_bus ();
  soc_bus_if gpio_bus ();
  soc_bus_if sys_bus ();

  // ------------------------------------------------------------
  // per-master remap and decode
  // ------------------------------------------------------------
  soc_remap_decode u_iwb_remap (
    .adr_i        (iwb_adr_i),
    .boot_remap_i (boot_remap),
    .adr_o        (iwb_adr_remap),
    .slave_o      (iwb_slave)
  );

  soc_remap_decode u_dwb_remap (
    .adr_i        (dwb_adr_i),
    .boot_remap_i (boot_remap),
    .adr_o        (dwb_adr_remap),
    .slave_o      (dwb_slave)
  );

  soc_bus_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .i_cyc_i   (iwb_cyc_i),
    .i_stb_i   (iwb_stb_i),
    .i_we_i    (iwb_we_i),
    .i_sel_i   (iwb_sel_i),
    .i_adr_i   (iwb_adr_remap),
    .i_dat_i   (iwb_dat_i),
    .i_slave_i (iwb_slave),
    .i_dat_o   (iwb_dat_o),
    .i_ack_o   (iwb_ack_o),
    .i_err_o   (iwb_err_o),
    .d_cyc_i   (dwb_cyc_i),
    .d_stb_i   (dwb_stb_i),
    .d_we_i    (dwb_we_i),
    .d_sel_i   (dwb_sel_i),
    .d_adr_i   (dwb_adr_remap),
    .d_dat_i   (dwb_dat_i),
    .d_slave_i (dwb_slave),
    .d_dat_o   (dwb_dat_o),
    .d_ack_o   (dwb_ack_o),
    .d_err_o   (dwb_err_o),
    .rom_bus   (rom_bus.master),
    .gpio_bus  (gpio_bus.master),
    .sys_bus   (sys_bus.master)
  );

  // ------------------------------------------------------------
  // slaves
  // ------------------------------------------------------------
  soc_boot_rom u_boot_rom (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (rom_bus.target)
  );

  soc_gpio u_gpio (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus          (gpio_bus.target),
    .gpio_pad_i   (gpio_pad_i),
    .gpio_pad_o   (gpio_pad_o),
    .gpio_padoe_o (gpio_padoe_o)
  );

  soc_sys_ctrl u_sys_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .boot_strap_i (boot_strap_i),
    .bus          (sys_bus.target),
    .boot_remap_o (boot_remap)  // feeds both decoders
  );

endmodule

`default_nettype wire

// ==== dv/soc_top_tb.sv ====
/* directed tests for the two-master bus core with one access per master at a time
   stops at the first mismatch or timeout */
`default_nettype none
`include "soc_defines.svh"

module soc_top_tb import soc_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 20;

  logic        clk_i;
  logic        rst_n_i;
  boot_strap_t boot_strap_i;
  bus_data_t   gpio_pad_i, gpio_pad_o, gpio_padoe_o;
  logic        iwb_cyc_i, iwb_stb_i, iwb_we_i, iwb_ack_o, iwb_err_o;
  bus_sel_t    iwb_sel_i;
  bus_addr_t   iwb_adr_i;
  bus_data_t   iwb_dat_i, iwb_dat_o;
  logic        dwb_cyc_i, dwb_stb_i, dwb_we_i, dwb_ack_o, dwb_err_o;
  bus_sel_t    dwb_sel_i;
  bus_addr_t   dwb_adr_i;
  bus_data_t   dwb_dat_i, dwb_dat_o;
  integer      seed = 32'hd748;

  soc_top soc_top_i (.*);

  always #50 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic stop_on_error();
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_remap(input string name, input boot_remap_t got,
                             input boot_remap_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // ------------------------------------------------------------
  // bus tasks with one idle cycle before each access
  // ------------------------------------------------------------
  task automatic iwb_access(input logic we, input bus_addr_t adr, input bus_data_t wdat,
                            output bus_data_t rdat, output logic ack, output logic err,
                            output time t_end);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    #1;
    iwb_cyc_i = 1'b1;
    iwb_stb_i = 1'b1;
    iwb_we_i  = we;
    iwb_adr_i = adr;
    iwb_dat_i = wdat;
    while (!iwb_ack_o && !iwb_err_o && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!iwb_ack_o && !iwb_err_o) begin
      $display("no ack or err on the instruction port within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end else begin
      rdat      = iwb_dat_o;
      ack       = iwb_ack_o;
      err       = iwb_err_o;
      t_end     = $time;
      iwb_cyc_i = 1'b0;
      iwb_stb_i = 1'b0;
      iwb_we_i  = 1'b0;
    end
  endtask

  task automatic dwb_access(input logic we, input bus_addr_t adr, input bus_data_t wdat,
                            output bus_data_t rdat, output logic ack, output logic err,
                            output time t_end);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    #1;
    dwb_cyc_i = 1'b1;
    dwb_stb_i = 1'b1;
    dwb_we_i  = we;
    dwb_adr_i = adr;
    dwb_dat_i = wdat;
    while (!dwb_ack_o && !dwb_err_o && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!dwb_ack_o && !dwb_err_o) begin
      $display("no ack or err on the data port within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end else begin
      rdat      = dwb_dat_o;
      ack       = dwb_ack_o;
      err       = dwb_err_o;
      t_end     = $time;
      dwb_cyc_i = 1'b0;
      dwb_stb_i = 1'b0;
      dwb_we_i  = 1'b0;
    end
  endtask

  task automatic apply_reset(input boot_strap_t strap);
    @(posedge clk_i);
    #1;
    boot_strap_i = strap;  // held steady through reset
    rst_n_i      = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_rom_boot();
    bus_data_t rd;
    logic      ack, err;
    time       t;
    apply_reset(4'h0);
    check_data("gpio_pad_o", gpio_pad_o, '0);
    check_data("gpio_padoe_o", gpio_padoe_o, '0);
    for (int w = 0; w < `SOC_ROM_WORDS; w++) begin
      iwb_access(1'b0, bus_addr_t'(w * 4), '0, rd, ack, err, t);
      check_flag("iwb_ack_o", ack, 1'b1);
      check_data("iwb_dat_o rom", rd, BOOT_ROM_IMAGE[w]);
    end
    dwb_access(1'b0, 32'h1000_0000 | `SOC_GPIO_OUT, '0, rd, ack, err, t);
    check_flag("dwb_ack_o", ack, 1'b1);
    check_data("dwb_dat_o gpio out", rd, '0);
    dwb_access(1'b0, 32'h1000_0000 | `SOC_GPIO_OE, '0, rd, ack, err, t);
    check_flag("dwb_ack_o", ack, 1'b1);
    check_data("dwb_dat_o gpio oe", rd, '0);
  endtask

  task automatic test_gpio_regs();
    bus_data_t out_val, oe_val, pad_val, rd;
    logic      ack, err;
    time       t;
    out_val = $random(seed);
    oe_val  = $random(seed);
    pad_val = $random(seed);
    dwb_access(1'b1, 32'h1000_0000 | `SOC_GPIO_OUT, out_val, rd, ack, err, t);
    dwb_access(1'b1, 32'h1000_0000 | `SOC_GPIO_OE, oe_val, rd, ack, err, t);
    check_data("gpio_pad_o", gpio_pad_o, out_val);
    check_data("gpio_padoe_o", gpio_padoe_o, oe_val);
    dwb_access(1'b0, 32'h1000_0000 | `SOC_GPIO_OUT, '0, rd, ack, err, t);
    check_data("dwb_dat_o gpio out", rd, out_val);
    dwb_access(1'b0, 32'h1000_0000 | `SOC_GPIO_OE, '0, rd, ack, err, t);
    check_data("dwb_dat_o gpio oe", rd, oe_val);
    gpio_pad_i = pad_val;  // sync delay is covered by the grant cycles
    dwb_access(1'b0, 32'h1000_0000 | `SOC_GPIO_IN, '0, rd, ack, err, t);
    check_data("dwb_dat_o gpio in", rd, pad_val);
  endtask

  task automatic test_strap_remap();
    bus_data_t rd;
    logic      ack, err;
    time       t;
    dwb_access(1'b0, 32'h2000_0000 | `SOC_SYS_STRAP, '0, rd, ack, err, t);
    check_flag("dwb_ack_o", ack, 1'b1);
    check_data("dwb_dat_o strap", rd, 32'h0);
    apply_reset(4'h6);  // low bits 2 map region 0 onto system control
    dwb_access(1'b0, 32'h2000_0000 | `SOC_SYS_STRAP, '0, rd, ack, err, t);
    check_data("dwb_dat_o strap", rd, 32'h6);
    dwb_access(1'b0, 32'h2000_0000 | `SOC_SYS_REMAP, '0, rd, ack, err, t);
    check_remap("boot_remap", boot_remap_t'(rd), 2'd2);
    iwb_access(1'b0, 32'h0000_0000 | `SOC_SYS_STRAP, '0, rd, ack, err, t);
    check_flag("iwb_ack_o", ack, 1'b1);
    check_data("iwb_dat_o remapped strap", rd, 32'h6);
  endtask

  task automatic test_remap_write();
    bus_data_t out_val, rd;
    logic      ack, err;
    time       t;
    out_val = $random(seed);
    dwb_access(1'b1, 32'h2000_0000 | `SOC_SYS_REMAP, 32'h1, rd, ack, err, t);
    dwb_access(1'b0, 32'h2000_0000 | `SOC_SYS_REMAP, '0, rd, ack, err, t);
    check_remap("boot_remap", boot_remap_t'(rd), 2'd1);
    dwb_access(1'b1, 32'h1000_0000 | `SOC_GPIO_OUT, out_val, rd, ack, err, t);
    iwb_access(1'b0, 32'h0000_0000 | `SOC_GPIO_OUT, '0, rd, ack, err, t);
    check_data("iwb_dat_o remapped gpio", rd, out_val);
    dwb_access(1'b1, 32'h2000_0000 | `SOC_SYS_REMAP, 32'h0, rd, ack, err, t);
    dwb_access(1'b0, 32'h2000_0000 | `SOC_SYS_REMAP, '0, rd, ack, err, t);
    check_flag("dwb_ack_o", ack, 1'b1);
    check_remap("boot_remap", boot_remap_t'(rd), 2'd0);
    iwb_access(1'b0, 32'h0000_0008, '0, rd, ack, err, t);
    check_data("iwb_dat_o rom", rd, BOOT_ROM_IMAGE[2]);
  endtask

  task automatic test_unmapped();
    bus_data_t rd;
    logic      ack, err;
    time       t;
    iwb_access(1'b0, 32'h3000_0000, '0, rd, ack, err, t);
    check_flag("iwb_err_o", err, 1'b1);
    check_flag("iwb_ack_o", ack, 1'b0);
    dwb_access(1'b1, 32'hF000_0010, 32'h1234_5678, rd, ack, err, t);
    check_flag("dwb_err_o", err, 1'b1);
    check_flag("dwb_ack_o", ack, 1'b0);
  endtask

  task automatic test_contention();
    bus_data_t out_val, i_rd, d_rd;
    logic      i_ack, i_err, d_ack, d_err;
    time       i_t, d_t;
    out_val = $random(seed);
    fork
      iwb_access(1'b0, 32'h0000_0014, '0, i_rd, i_ack, i_err, i_t);
      dwb_access(1'b1, 32'h1000_0000 | `SOC_GPIO_OUT, out_val, d_rd, d_ack, d_err, d_t);
    join
    check_flag("iwb_ack_o", i_ack, 1'b1);
    check_flag("dwb_ack_o", d_ack, 1'b1);
    check_data("iwb_dat_o rom", i_rd, BOOT_ROM_IMAGE[5]);
    check_data("gpio_pad_o", gpio_pad_o, out_val);
    check_flag("dwb ack not after iwb ack", d_t <= i_t, 1'b1);  // data has priority
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    boot_strap_i = '0;
    gpio_pad_i   = '0;
    iwb_cyc_i    = 1'b0;
    iwb_stb_i    = 1'b0;
    iwb_we_i     = 1'b0;
    iwb_sel_i    = '1;
    iwb_adr_i    = '0;
    iwb_dat_i    = '0;
    dwb_cyc_i    = 1'b0;
    dwb_stb_i    = 1'b0;
    dwb_we_i     = 1'b0;
    dwb_sel_i    = '1;
    dwb_adr_i    = '0;
    dwb_dat_i    = '0;
    test_rom_boot();
    test_gpio_regs();
    test_strap_remap();
    test_remap_write();
    test_unmapped();
    test_contention();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/soc_pkg.sv
src/soc_bus_if.sv
src/soc_remap_decode.sv
src/soc_bus_arbiter.sv
src/soc_boot_rom.sv
src/soc_sys_ctrl.sv
src/soc_gpio.sv
src/soc_top.sv
dv/soc_top_tb.sv

// ==== Bender.yml ====
package:
  name: soc_bus_core

sources:
  - include_dirs:
      - src
    files:
      - src/soc_pkg.sv
      - src/soc_bus_if.sv
      - src/soc_remap_decode.sv
      - src/soc_bus_arbiter.sv
      - src/soc_boot_rom.sv
      - src/soc_sys_ctrl.sv
      - src/soc_gpio.sv
      - src/soc_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/soc_top_tb.sv
